// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module tb_xvid_top \
    -o tb_xvid_top \
    && ./obj_dir/tb_xvid_top > sim.log 2>&1 \
    || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim.f ====
+incdir+src
src/vid_pkg.sv
src/vram_ifs.sv
src/vram.sv
src/vram_arb.sv
src/host_regs.sv
src/text_fetch.sv
src/xvid_top.sv
verification/tb_xvid_top.sv

// ==== src/host_regs.sv ====
// host register file, turns bus register writes into memory requests and holds read data
`timescale 1ns/1ps

`include "vid_consts.svh"

module host_regs (
    input  logic            clk,
    input  logic            reset,
    input  logic            bus_cs,
    input  logic            bus_wr,
    input  logic [1:0]      bus_reg,
    input  vid_pkg::word_t  bus_wdata,
    output vid_pkg::word_t  bus_rdata,
    output logic            bus_busy,
    output logic            disp_enable,
    host_port_if.requester  host
);
    import vid_pkg::*;

    addr_t wr_addr;
    addr_t rd_addr;
    mask_t wr_mask;
    logic  req_q;       // request waiting for ack
    logic  req_wr;
    logic  rd_wait;     // read issued, word arrives this cycle
    addr_t req_addr;
    word_t req_wdata;
    mask_t req_mask;
    word_t rd_latch;
    logic  bus_write;
    logic  start_write;
    logic  start_read;
    logic  next_read;

    assign bus_write   = bus_cs && bus_wr && !bus_busy;  // ignored while busy
    assign start_write = bus_write && (bus_reg == `REG_DATA);
    assign start_read  = bus_write && (bus_reg == `REG_RD_ADDR);
    // a bus read of DATA fetches the word at the read address
    assign next_read   = bus_cs && !bus_wr && !bus_busy && (bus_reg == `REG_DATA);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_addr     <= '0;
            rd_addr     <= '0;
            wr_mask     <= 4'hF;
            disp_enable <= 1'b0;
            req_q       <= 1'b0;
            req_wr      <= 1'b0;
            rd_wait     <= 1'b0;
        end else begin
            rd_wait <= req_q && host.ack && !req_wr;
            if (req_q && host.ack) begin
                req_q <= 1'b0;
            end
            if (start_write || start_read || next_read) begin
                req_q  <= 1'b1;
                req_wr <= start_write;
            end
            if (bus_write) begin
                case (bus_reg)
                    `REG_WR_ADDR: wr_addr <= bus_wdata;
                    `REG_DATA:    wr_addr <= wr_addr + 16'd1;
                    `REG_RD_ADDR: rd_addr <= bus_wdata + 16'd1;  // next read follows
                    `REG_CTRL: begin
                        wr_mask     <= bus_wdata[3:0];
                        disp_enable <= bus_wdata[15];
                    end
                endcase
            end
            if (next_read) begin
                rd_addr <= rd_addr + 16'd1;
            end
        end
    end

    // request fields, held steady while req_q is high
    always_ff @(posedge clk) begin
        if (start_write) begin
            req_addr  <= wr_addr;
            req_wdata <= bus_wdata;
            req_mask  <= wr_mask;
        end else if (start_read) begin
            req_addr <= bus_wdata;
        end else if (next_read) begin
            req_addr <= rd_addr;
        end
        if (rd_wait) begin
            rd_latch <= host.rdata;
        end
    end

    assign host.req   = req_q;
    assign host.wr    = req_wr;
    assign host.mask  = req_mask;
    assign host.addr  = req_addr;
    assign host.wdata = req_wdata;

    assign bus_busy  = req_q || rd_wait;
    assign bus_rdata = rd_latch;

endmodule

// ==== src/text_fetch.sv ====
// text display engine, scans the screen, fetches tile and font words and shifts out pixels
`timescale 1ns/1ps

`include "vid_consts.svh"

module text_fetch (
    input  logic            clk,
    input  logic            reset,
    input  logic            disp_enable,
    output logic            disp_req,
    output vid_pkg::addr_t  disp_addr,
    input  vid_pkg::word_t  disp_data,
    output logic            pixel_valid,
    output vid_pkg::color_t pixel_color,
    output logic            frame_start
);
    import vid_pkg::*;

    localparam int VIS_W = `VID_COLS * 8;
    localparam int VIS_H = `VID_ROWS * 8;

    logic         run_q;          // counters advancing
    logic [5:0]   h_cnt;
    logic [5:0]   h_nxt;
    logic [4:0]   v_cnt;
    logic [4:0]   v_nxt;
    logic         cell_start_nxt;
    logic         cell_end;
    fetch_state_t state;
    fetch_state_t state_d;
    word_t        tile_q;
    logic [7:0]   font_q;
    logic [7:0]   shift_q;
    color_t       fg_q;
    color_t       bg_q;
    logic [3:0]   pix_left;       // pixels left in the current cell
    char_t        tile_char;
    addr_t        tile_addr;
    addr_t        font_addr;

    always_comb begin
        h_nxt = '0;
        v_nxt = '0;
        if (run_q) begin
            if (h_cnt == 6'(`VID_H_TOTAL - 1)) begin
                v_nxt = (v_cnt == 5'(`VID_V_TOTAL - 1)) ? 5'd0 : v_cnt + 5'd1;
            end else begin
                h_nxt = h_cnt + 6'd1;
                v_nxt = v_cnt;
            end
        end
    end

    assign cell_start_nxt = disp_enable && (h_nxt[2:0] == 3'd0)
                            && (h_nxt < 6'(VIS_W)) && (v_nxt < 5'(VIS_H));
    assign cell_end       = (state == HOLD) && (h_cnt[2:0] == 3'd7);

    always_comb begin
        case (state)
            TILE_RD:   state_d = TILE_WAIT;
            TILE_WAIT: state_d = FONT_RD;
            FONT_RD:   state_d = FONT_WAIT;
            FONT_WAIT: state_d = HOLD;
            HOLD:      state_d = cell_end ? IDLE : HOLD;
            default:   state_d = IDLE;
        endcase
        if (cell_start_nxt) begin
            state_d = TILE_RD;
        end
        if (!disp_enable) begin
            state_d = IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            run_q    <= 1'b0;
            h_cnt    <= '0;
            v_cnt    <= '0;
            state    <= IDLE;
            pix_left <= '0;
        end else begin
            run_q <= disp_enable;
            h_cnt <= disp_enable ? h_nxt : 6'd0;  // held at zero when off
            v_cnt <= disp_enable ? v_nxt : 5'd0;
            state <= state_d;
            if (cell_end) begin
                pix_left <= 4'd8;
            end else if (pix_left != 4'd0) begin
                pix_left <= pix_left - 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == TILE_WAIT) begin
            tile_q <= disp_data;
        end
        if (state == FONT_WAIT) begin
            font_q <= disp_data[7:0];  // high byte unused
        end
        if (cell_end) begin
            shift_q <= font_q;
            fg_q    <= tile_q[15:12];
            bg_q    <= tile_q[11:8];
        end else begin
            shift_q <= {shift_q[6:0], 1'b0};  // bit 7 is the leftmost pixel
        end
    end

    assign tile_char = tile_q[7:0];
    assign tile_addr = `VID_TILE_BASE + addr_t'(v_cnt[4:3]) * addr_t'(`VID_COLS)
                       + addr_t'(h_cnt[5:3]);
    assign font_addr = `VID_FONT_BASE + {5'b0, tile_char, 3'b000} + addr_t'(v_cnt[2:0]);

    assign disp_req  = (state == TILE_RD) || (state == FONT_RD);
    assign disp_addr = (state == FONT_RD) ? font_addr : tile_addr;

    assign pixel_valid = (pix_left != 4'd0);
    assign pixel_color = shift_q[7] ? fg_q : bg_q;
    assign frame_start = run_q && (h_cnt == 6'd0) && (v_cnt == 5'd0);

endmodule

// ==== src/vid_consts.svh ====
// screen geometry, memory map and host register numbers, included by the modules that use them
`ifndef VID_CONSTS_SVH
`define VID_CONSTS_SVH

// text cells per line and per column, each cell 8x8 pixels
`define VID_COLS 4
`define VID_ROWS 2

// clocks per scanline and scanlines per frame
`define VID_H_TOTAL 40
`define VID_V_TOTAL 18

// tile map at the bottom, font rows in the top 4K words
`define VID_TILE_BASE 16'h0000
`define VID_FONT_BASE 16'hF000

// host register numbers on bus_reg
`define REG_WR_ADDR 2'd0
`define REG_DATA 2'd1
`define REG_RD_ADDR 2'd2
`define REG_CTRL 2'd3

`endif

// ==== src/vid_pkg.sv ====
// shared types of the text video subsystem, imported by the interfaces and the RTL modules
package vid_pkg;

    // video memory word address, 64K words
    typedef logic [15:0] addr_t;

    // one memory data word
    typedef logic [15:0] word_t;

    // write enable per nibble, bit 0 is data bits 3..0
    typedef logic [3:0] mask_t;

    // pixel color index
    typedef logic [3:0] color_t;

    // character index from the low byte of a tile word
    // tile word bits 11..8 hold background, bits 15..12 foreground
    typedef logic [7:0] char_t;

    // text_fetch sequence within one 8 clock cell
    typedef enum logic [2:0] {
        IDLE,       // no cell being fetched
        TILE_RD,    // tile word address on the bus
        TILE_WAIT,  // tile word returning
        FONT_RD,    // font row address on the bus
        FONT_WAIT,  // font row returning
        HOLD        // wait for the end of the cell
    } fetch_state_t;

endpackage

// ==== src/vram.sv ====
// 64K x 16 video memory in four 16K banks with nibble write mask and one cycle read latency
`timescale 1ns/1ps

module vram (
    input  logic       clk,
    vram_bus_if.target mem
);
    import vid_pkg::*;

    localparam int BANK_WORDS = 16384;

    logic [1:0]  read_bank;    // bank of the last selected access
    logic [13:0] bank_addr;
    word_t       bank_rd [4];

    assign bank_addr = mem.address[13:0];

    for (genvar b = 0; b < 4; b++) begin : g_bank
        word_t ram [BANK_WORDS];
        word_t rd_q;
        logic  bank_sel;

        assign bank_sel = mem.sel && (mem.address[15:14] == 2'(b));

        // start from zeroed contents
        initial begin
            for (int i = 0; i < BANK_WORDS; i++) begin
                ram[i] = '0;
            end
        end

        always_ff @(posedge clk) begin
            if (bank_sel) begin
                if (mem.wr_en) begin
                    for (int n = 0; n < 4; n++) begin
                        if (mem.wr_mask[n]) begin
                            ram[bank_addr][n*4 +: 4] <= mem.data_in[n*4 +: 4];
                        end
                    end
                end
                rd_q <= ram[bank_addr];  // old contents on a write
            end
        end

        assign bank_rd[b] = rd_q;
    end

    // remember which bank answers next cycle
    always_ff @(posedge clk) begin
        if (mem.sel) begin
            read_bank <= mem.address[15:14];
        end
    end

    assign mem.data_out = bank_rd[read_bank];

endmodule

// ==== src/vram_arb.sv ====
// single port arbiter, display fetches always win and the host gets the remaining cycles
`timescale 1ns/1ps

module vram_arb (
    input  logic            clk,
    input  logic            reset,
    host_port_if.arbiter    host,
    input  logic            disp_req,
    input  vid_pkg::addr_t  disp_addr,
    output vid_pkg::word_t  disp_data,
    vram_bus_if.initiator   mem
);
    import vid_pkg::*;

    logic host_grant;
    logic disp_owner;   // data_out this cycle answers the display
    logic host_owner;   // data_out this cycle answers a host read

    // display strobe is never refused
    assign host_grant = host.req && !disp_req;
    assign host.ack   = host_grant;

    assign mem.sel     = disp_req || host.req;
    assign mem.wr_en   = host_grant && host.wr;  // display only reads
    assign mem.wr_mask = disp_req ? mask_t'(0) : host.mask;
    assign mem.address = disp_req ? disp_addr : host.addr;
    assign mem.data_in = disp_req ? word_t'(0) : host.wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            disp_owner <= 1'b0;
            host_owner <= 1'b0;
        end else begin
            disp_owner <= disp_req;
            host_owner <= host_grant && !host.wr;
        end
    end

    // steer the returning word to its owner
    assign disp_data  = disp_owner ? mem.data_out : word_t'(0);
    assign host.rdata = host_owner ? mem.data_out : word_t'(0);

endmodule

// ==== src/vram_ifs.sv ====
// memory bus and host request interfaces, instantiated in the top level and passed to the RTL
`timescale 1ns/1ps

interface vram_bus_if;
    import vid_pkg::*;

    logic  sel;        // access this cycle
    logic  wr_en;
    mask_t wr_mask;
    addr_t address;
    word_t data_in;
    word_t data_out;   // valid the cycle after sel

    modport initiator (output sel, wr_en, wr_mask, address, data_in, input data_out);
    modport target (input sel, wr_en, wr_mask, address, data_in, output data_out);
endinterface

interface host_port_if;
    import vid_pkg::*;

    logic  req;    // held until ack
    logic  wr;
    mask_t mask;
    addr_t addr;
    word_t wdata;
    logic  ack;    // pulse when the access goes to memory
    word_t rdata;  // valid the cycle after ack of a read

    modport requester (output req, wr, mask, addr, wdata, input ack, rdata);
    modport arbiter (input req, wr, mask, addr, wdata, output ack, rdata);
endinterface

// ==== src/xvid_top.sv ====
// top level of the text video subsystem, host bus in and pixel stream out
`timescale 1ns/1ps

module xvid_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            bus_cs,
    input  logic            bus_wr,
    input  logic [1:0]      bus_reg,
    input  vid_pkg::word_t  bus_wdata,
    output vid_pkg::word_t  bus_rdata,
    output logic            bus_busy,
    output logic            pixel_valid,
    output vid_pkg::color_t pixel_color,
    output logic            frame_start
);
    import vid_pkg::*;

    logic  disp_enable;
    logic  disp_req;
    addr_t disp_addr;
    word_t disp_data;

    vram_bus_if  u_mem_bus ();
    host_port_if u_host_port ();

    host_regs u_host_regs (
        .clk         (clk),
        .reset       (reset),
        .bus_cs      (bus_cs),
        .bus_wr      (bus_wr),
        .bus_reg     (bus_reg),
        .bus_wdata   (bus_wdata),
        .bus_rdata   (bus_rdata),
        .bus_busy    (bus_busy),
        .disp_enable (disp_enable),
        .host        (u_host_port.requester)
    );

    text_fetch u_text_fetch (
        .clk         (clk),
        .reset       (reset),
        .disp_enable (disp_enable),
        .disp_req    (disp_req),
        .disp_addr   (disp_addr),
        .disp_data   (disp_data),
        .pixel_valid (pixel_valid),
        .pixel_color (pixel_color),
        .frame_start (frame_start)
    );

    vram_arb u_vram_arb (
        .clk       (clk),
        .reset     (reset),
        .host      (u_host_port.arbiter),
        .disp_req  (disp_req),
        .disp_addr (disp_addr),
        .disp_data (disp_data),
        .mem       (u_mem_bus.initiator)
    );

    vram u_vram (
        .clk (clk),
        .mem (u_mem_bus.target)
    );

endmodule

// ==== verification/tb_xvid_top.sv ====
// directed testbench for xvid_top, the simulation top that drives the host bus and checks pixels
`timescale 1ns/1ps

`include "vid_consts.svh"

module tb_xvid_top;
    import vid_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int VIS_W        = `VID_COLS * 8;
    localparam int VIS_H        = `VID_ROWS * 8;
    localparam int FRAME_CYCLES = `VID_H_TOTAL * `VID_V_TOTAL;
    // reset, host tests, screen load, frame wait and scan, host traffic while scanning
    localparam int EST_CYCLES   = 8 + 600 + 500 + 3 * FRAME_CYCLES + 400;

    logic       clk;
    logic       reset;
    logic       bus_cs;
    logic       bus_wr;
    logic [1:0] bus_reg;
    word_t      bus_wdata;
    word_t      bus_rdata;
    logic       bus_busy;
    logic       pixel_valid;
    color_t     pixel_color;
    logic       frame_start;

    word_t       model [65536];  // expected VRAM contents
    mask_t       cur_mask;       // mask applied to DATA writes
    logic [31:0] lfsr;

    xvid_top u_xvid_top (
        .clk         (clk),
        .reset       (reset),
        .bus_cs      (bus_cs),
        .bus_wr      (bus_wr),
        .bus_reg     (bus_reg),
        .bus_wdata   (bus_wdata),
        .bus_rdata   (bus_rdata),
        .bus_busy    (bus_busy),
        .pixel_valid (pixel_valid),
        .pixel_color (pixel_color),
        .frame_start (frame_start)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(EST_CYCLES * 2 * CLK_PERIOD);
        stop_on_error("watchdog timeout, the tests did not finish in time");
    end

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);  // one step per bit
            r = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    // color of pixel x on visible line y from the model
    function automatic color_t expected_pixel(input int x, input int y);
        addr_t      ta;
        addr_t      fa;
        word_t      tile;
        logic [7:0] row_bits;
        ta = addr_t'(`VID_TILE_BASE + (y / 8) * `VID_COLS + x / 8);
        tile = model[ta];
        fa = addr_t'(`VID_FONT_BASE + 8 * int'(tile[7:0]) + y % 8);
        row_bits = model[fa][7:0] >> (7 - x % 8);  // bit 7 is leftmost
        return row_bits[0] ? tile[15:12] : tile[11:8];
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        assert (got === exp)
        else stop_on_error($sformatf("FAILED at %0t: %s, got %h, expected %h",
                                     $time, what, got, exp));
    endtask

    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic clear_model();
        addr_t a;
        a = '0;
        repeat (65536) begin
            model[a] = '0;
            a++;
        end
    endtask

    task automatic model_write(input addr_t a, input word_t d);
        word_t wmask;
        wmask = {{4{cur_mask[3]}}, {4{cur_mask[2]}}, {4{cur_mask[1]}}, {4{cur_mask[0]}}};
        model[a] = (model[a] & ~wmask) | (d & wmask);
    endtask

    task automatic wait_not_busy();
        int cycles;
        cycles = 0;
        while (bus_busy) begin
            tick();
            cycles++;
            assert (cycles <= 4)
            else stop_on_error($sformatf("bus_busy stayed high too long at %0t", $time));
        end
    endtask

    task automatic reg_write(input logic [1:0] num, input word_t value);
        bus_cs    = 1'b1;
        bus_wr    = 1'b1;
        bus_reg   = num;
        bus_wdata = value;
        tick();
        bus_cs = 1'b0;
        bus_wr = 1'b0;
        wait_not_busy();
    endtask

    task automatic reg_read_word(input addr_t a, output word_t d);
        reg_write(`REG_RD_ADDR, a);
        d = bus_rdata;
    endtask

    // bus read of DATA, fetches at the auto-incremented read address
    task automatic read_next_word(output word_t d);
        bus_cs  = 1'b1;
        bus_wr  = 1'b0;
        bus_reg = `REG_DATA;
        tick();
        bus_cs = 1'b0;
        wait_not_busy();
        d = bus_rdata;
    endtask

    task automatic set_ctrl(input logic enable, input mask_t m);
        cur_mask = m;
        reg_write(`REG_CTRL, {enable, 11'd0, m});
    endtask

    task automatic write_run(input addr_t base, input int n);
        word_t d;
        reg_write(`REG_WR_ADDR, base);
        for (int i = 0; i < n; i++) begin
            d = rand_bits(16);
            reg_write(`REG_DATA, d);
            model_write(base + addr_t'(i), d);
        end
    endtask

    task automatic read_run(input addr_t base, input int n);
        word_t d;
        reg_read_word(base, d);
        check_word($sformatf("read at %h", base), d, model[base]);
        for (int i = 1; i < n; i++) begin
            read_next_word(d);
            check_word($sformatf("read at %h", base + addr_t'(i)), d, model[base + addr_t'(i)]);
        end
    endtask

    task automatic check_reset_state();
        word_t d;
        check_word("bus_busy after reset", word_t'(bus_busy), 16'h0);
        check_word("pixel_valid after reset", word_t'(pixel_valid), 16'h0);
        check_word("frame_start after reset", word_t'(frame_start), 16'h0);
        reg_read_word(16'h0000, d);
        check_word("word at address 0", d, model[16'h0000]);
    endtask

    task automatic run_auto_increment();
        addr_t base;
        base = rand_bits(16);
        write_run(base, 16);
        read_run(base, 16);
    endtask

    task automatic check_nibble_mask();
        mask_t patterns [2] = '{4'b0110, 4'b1001};
        addr_t a;
        word_t d;
        for (int p = 0; p < 2; p++) begin
            a = 16'h1230 + addr_t'(p);
            set_ctrl(1'b0, 4'hF);
            write_run(a, 1);
            set_ctrl(1'b0, patterns[p]);
            write_run(a, 1);  // merged under the partial mask
            reg_read_word(a, d);
            check_word("nibble masked write", d, model[a]);
        end
        set_ctrl(1'b0, 4'hF);
    endtask

    task automatic cross_banks();
        addr_t spots [12] = '{16'h3FFE, 16'h3FFF, 16'h4000, 16'h4001, 16'h7FFF, 16'h8000,
                              16'hBFFF, 16'hC000, 16'h0005, 16'h4005, 16'h8005, 16'hC005};
        word_t d;
        for (int i = 0; i < 12; i++) begin
            write_run(spots[i], 1);
        end
        for (int i = 0; i < 12; i++) begin
            reg_read_word(spots[i], d);
            check_word($sformatf("bank word at %h", spots[i]), d, model[spots[i]]);
        end
    endtask

    task automatic scan_display();
        addr_t fa;
        int    waited;
        write_run(`VID_TILE_BASE, `VID_COLS * `VID_ROWS);
        // font rows of every character the tiles use
        for (int i = 0; i < `VID_COLS * `VID_ROWS; i++) begin
            fa = addr_t'(`VID_FONT_BASE + 8 * int'(model[`VID_TILE_BASE + addr_t'(i)][7:0]));
            write_run(fa, 8);
        end
        set_ctrl(1'b1, 4'hF);
        waited = 0;
        while (!frame_start) begin
            tick();
            waited++;
            assert (waited <= FRAME_CYCLES + 8)
            else stop_on_error("frame_start never appeared after enabling the display");
        end
        for (int y = 0; y < VIS_H; y++) begin
            waited = 0;
            while (!pixel_valid) begin
                tick();
                waited++;
                assert (waited <= `VID_H_TOTAL)
                else stop_on_error($sformatf("no pixel run found for line %0d", y));
            end
            // first pixel comes 8 clocks into the line
            check_word($sformatf("clocks before the pixel run of line %0d", y),
                       word_t'(waited), 16'd8);
            for (int x = 0; x < VIS_W; x++) begin
                check_word($sformatf("pixel_valid x %0d line %0d", x, y),
                           word_t'(pixel_valid), 16'h1);
                check_word($sformatf("pixel color x %0d line %0d", x, y),
                           word_t'(pixel_color), word_t'(expected_pixel(x, y)));
                check_word($sformatf("frame_start x %0d line %0d", x, y),
                           word_t'(frame_start), 16'h0);
                tick();
            end
            check_word($sformatf("pixel_valid after line %0d", y), word_t'(pixel_valid), 16'h0);
        end
        // blank lines up to the next frame carry no pixels
        waited = 0;
        while (!frame_start) begin
            check_word("pixel_valid in blank lines", word_t'(pixel_valid), 16'h0);
            tick();
            waited++;
        end
        check_word("clocks of the blank lines", word_t'(waited),
                   word_t'((`VID_V_TOTAL - VIS_H) * `VID_H_TOTAL));
    endtask

    task automatic access_during_display();
        addr_t base;
        for (int k = 0; k < 6; k++) begin
            base = 16'h2000 + rand_bits(13);
            repeat (rand_bits(3)) tick();  // vary the phase against display slots
            write_run(base, 4);
            repeat (rand_bits(3)) tick();
            read_run(base, 4);
        end
    endtask

    initial begin
        lfsr      = 32'h53065782;
        cur_mask  = 4'hF;
        reset     = 1'b1;
        bus_cs    = 1'b0;
        bus_wr    = 1'b0;
        bus_reg   = 2'd0;
        bus_wdata = '0;
        clear_model();
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;
        check_reset_state();
        run_auto_increment();
        check_nibble_mask();
        cross_banks();
        scan_display();
        access_during_display();
        $display("Simulation passed");
        $finish;
    end

endmodule
